// ==== source/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  exec_pkg::alu_op_e           aluop_i,
    input  logic [exec_pkg::WORD_W-1:0] reg1_i,
    input  logic [exec_pkg::WORD_W-1:0] reg2_i,
    input  logic [exec_pkg::WORD_W-1:0] hi_i,
    input  logic [exec_pkg::WORD_W-1:0] lo_i,
    input  logic                        wreg_i,
    output logic [exec_pkg::WORD_W-1:0] result_o,
    output logic                        wreg_o
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(WORD_W) + 1;   // holds 0..WORD_W

    logic [SHAMT_W-1:0] shamt;
    logic [WORD_W-1:0]  sum;
    logic               is_sub;
    logic               ov;

    // leading bits equal to bit_val counted from the msb
    function automatic logic [CNT_W-1:0] lead_count(input logic [WORD_W-1:0] word,
                                                    input logic              bit_val);
        logic [CNT_W-1:0] cnt;
        logic             in_run;
        cnt    = '0;
        in_run = 1'b1;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (in_run && (word[i] == bit_val)) begin
                cnt = cnt + 1'b1;
            end else begin
                in_run = 1'b0;    // first differing bit ends the run
            end
        end
        return cnt;
    endfunction

    assign shamt  = reg1_i[SHAMT_W-1:0];
    assign is_sub = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU);
    assign sum    = is_sub ? (reg1_i - reg2_i) : (reg1_i + reg2_i);

    // add overflows with like signs, sub with unlike signs, when the result sign flips
    assign ov = ((reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1]) == is_sub) &&
                (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    assign wreg_o = ((aluop_i == OP_ADD) || (aluop_i == OP_SUB)) && ov ? 1'b0 : wreg_i;

    always_comb begin
        case (aluop_i)
            OP_OR:   result_o = reg1_i | reg2_i;
            OP_AND:  result_o = reg1_i & reg2_i;
            OP_NOR:  result_o = ~(reg1_i | reg2_i);
            OP_XOR:  result_o = reg1_i ^ reg2_i;
            OP_SLL:  result_o = reg2_i << shamt;
            OP_SRL:  result_o = reg2_i >> shamt;
            OP_SRA:  result_o = $unsigned($signed(reg2_i) >>> shamt);   // sign fill
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                result_o = sum;
            end
            OP_SLT:  result_o = WORD_W'($signed(reg1_i) < $signed(reg2_i));
            OP_SLTU: result_o = WORD_W'(reg1_i < reg2_i);
            OP_CLZ:  result_o = WORD_W'(lead_count(reg1_i, 1'b0));
            OP_CLO:  result_o = WORD_W'(lead_count(reg1_i, 1'b1));
            OP_MFHI: result_o = hi_i;
            OP_MFLO: result_o = lo_i;
            default: result_o = '0;          // MUL is picked at the top level
        endcase
    end

endmodule

`default_nettype wire

// ==== source/div_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_counter #(
    parameter int WORD_W = 32
) (
    input  logic clk,
    input  logic reset_i,
    input  logic run_i,
    output logic last_o
);

    localparam int CNT_W = $clog2(WORD_W);

    logic [CNT_W-1:0] count_q;    // iterations done so far

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign last_o = run_i && (count_q == CNT_W'(WORD_W - 1));   // final iteration

endmodule

`default_nettype wire

// ==== source/div_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_datapath #(
    parameter int WORD_W = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              start_i,
    input  logic              run_i,
    input  logic              signed_i,
    input  logic [WORD_W-1:0] dividend_i,
    input  logic [WORD_W-1:0] divisor_i,
    output logic [WORD_W-1:0] quotient_o,
    output logic [WORD_W-1:0] remainder_o
);

    logic [WORD_W-1:0] rem_q;        // partial remainder
    logic [WORD_W-1:0] quo_q;        // dividend bits shift out, quotient bits shift in
    logic [WORD_W-1:0] dvsr_q;
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic              dvnd_neg;
    logic              dvsr_neg;
    logic [WORD_W-1:0] dvnd_mag;
    logic [WORD_W-1:0] dvsr_mag;
    logic [WORD_W:0]   shifted;
    logic [WORD_W:0]   diff;
    logic              fits;

    assign dvnd_neg = signed_i && dividend_i[WORD_W-1];
    assign dvsr_neg = signed_i && divisor_i[WORD_W-1];
    assign dvnd_mag = dvnd_neg ? -dividend_i : dividend_i;
    assign dvsr_mag = dvsr_neg ? -divisor_i : divisor_i;

    // one restoring step
    assign shifted = {rem_q, quo_q[WORD_W-1]};
    assign diff    = shifted - {1'b0, dvsr_q};
    assign fits    = shifted >= {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            neg_quo_q <= 1'b0;
            neg_rem_q <= 1'b0;
        end else if (start_i) begin
            neg_quo_q <= dvnd_neg ^ dvsr_neg;
            neg_rem_q <= dvnd_neg;    // remainder follows the dividend
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q  <= '0;
            quo_q  <= dvnd_mag;
            dvsr_q <= dvsr_mag;
        end else if (run_i) begin
            rem_q <= fits ? diff[WORD_W-1:0] : shifted[WORD_W-1:0];
            quo_q <= {quo_q[WORD_W-2:0], fits};
        end
    end

    // divide by zero falls out as all-ones quotient, remainder = dividend
    assign quotient_o  = neg_quo_q ? -quo_q : quo_q;
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;

endmodule

`default_nettype wire

// ==== source/exec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
    input  logic                clk,
    input  logic                reset_i,
    input  exec_pkg::alu_op_e   aluop_i,
    input  logic                div_last_i,
    output logic                mul_signed_o,
    output logic                acc_load_o,
    output logic                acc_sub_o,
    output logic                div_start_o,
    output logic                div_run_o,
    output logic                div_signed_o,
    output logic                hi_we_o,
    output logic                lo_we_o,
    output exec_pkg::hilo_src_e hilo_sel_o,
    output logic                stall_o
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACC,         // second cycle of MADD family
        DIV_RUN,     // divider iterating
        DIV_DONE     // result written to HI/LO
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   is_acc;
    logic   is_div;

    assign is_acc = (aluop_i == OP_MADD) || (aluop_i == OP_MADDU) ||
                    (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);
    assign is_div = (aluop_i == OP_DIV) || (aluop_i == OP_DIVU);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (is_acc) begin
                    state_d = ACC;
                end else if (is_div) begin
                    state_d = DIV_RUN;
                end
            end
            ACC:      state_d = IDLE;
            DIV_RUN:  state_d = div_last_i ? DIV_DONE : DIV_RUN;
            default:  state_d = IDLE;
        endcase
    end

    assign mul_signed_o = (aluop_i == OP_MUL) || (aluop_i == OP_MULT) ||
                          (aluop_i == OP_MADD) || (aluop_i == OP_MSUB);
    assign acc_sub_o    = (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);
    assign div_signed_o = (aluop_i == OP_DIV);
    assign acc_load_o   = (state_q == IDLE) && is_acc;
    assign div_start_o  = (state_q == IDLE) && is_div;
    assign div_run_o    = (state_q == DIV_RUN);
    assign stall_o      = ((state_q == IDLE) && (is_acc || is_div)) || div_run_o;

    // HI/LO writes happen in the completing cycle only
    always_comb begin
        hi_we_o    = 1'b0;
        lo_we_o    = 1'b0;
        hilo_sel_o = HILO_REG1;
        case (state_q)
            IDLE: begin
                if ((aluop_i == OP_MULT) || (aluop_i == OP_MULTU)) begin
                    hi_we_o    = 1'b1;
                    lo_we_o    = 1'b1;
                    hilo_sel_o = HILO_PROD;
                end else if (aluop_i == OP_MTHI) begin
                    hi_we_o = 1'b1;
                end else if (aluop_i == OP_MTLO) begin
                    lo_we_o = 1'b1;
                end
            end
            ACC: begin
                hi_we_o    = 1'b1;
                lo_we_o    = 1'b1;
                hilo_sel_o = HILO_ACC;
            end
            DIV_DONE: begin
                hi_we_o    = 1'b1;
                lo_we_o    = 1'b1;
                hilo_sel_o = HILO_DIV;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int WORD_W  = 32;   // data word width
    localparam int SHAMT_W = 5;    // shift amount taken from reg1

    typedef enum logic [4:0] {
        OP_NOP,                    // no operation with a zero result
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,                    // write suppressed on signed overflow
        OP_ADDU,
        OP_SUB,                    // write suppressed on signed overflow
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,                    // low word of signed product
        OP_MULT,
        OP_MULTU,
        OP_MADD,                   // two-cycle accumulate group
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_MTHI,
        OP_MTLO,
        OP_MFHI,
        OP_MFLO,
        OP_DIV,                    // iterative over 34 cycles in total
        OP_DIVU
    } alu_op_e;

    // what HI/LO is loaded from
    typedef enum logic [1:0] {
        HILO_REG1,                 // MTHI / MTLO
        HILO_PROD,                 // MULT / MULTU
        HILO_ACC,                  // MADD family
        HILO_DIV                   // HI gets remainder, LO quotient
    } hilo_src_e;

endpackage

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                        clk,
    input  logic                        reset_i,
    input  exec_pkg::alu_op_e           aluop_i,
    input  logic [exec_pkg::WORD_W-1:0] reg1_i,
    input  logic [exec_pkg::WORD_W-1:0] reg2_i,
    input  logic                        wreg_i,
    output logic [exec_pkg::WORD_W-1:0] wdata_o,
    output logic                        wreg_o,
    output logic [exec_pkg::WORD_W-1:0] hi_o,
    output logic [exec_pkg::WORD_W-1:0] lo_o,
    output logic                        stall_o
);
    import exec_pkg::*;

    logic                mul_signed;
    logic                acc_load;
    logic                acc_sub;
    logic                div_start;
    logic                div_run;
    logic                div_signed;
    logic                div_last;
    logic                hi_we;
    logic                lo_we;
    hilo_src_e           hilo_sel;
    logic [2*WORD_W-1:0] product;
    logic [2*WORD_W-1:0] acc_sum;
    logic [WORD_W-1:0]   quotient;
    logic [WORD_W-1:0]   remainder;
    logic [WORD_W-1:0]   hi;
    logic [WORD_W-1:0]   lo;
    logic [WORD_W-1:0]   alu_result;

    exec_ctrl ctrl_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .aluop_i      (aluop_i),
        .div_last_i   (div_last),
        .mul_signed_o (mul_signed),
        .acc_load_o   (acc_load),
        .acc_sub_o    (acc_sub),
        .div_start_o  (div_start),
        .div_run_o    (div_run),
        .div_signed_o (div_signed),
        .hi_we_o      (hi_we),
        .lo_we_o      (lo_we),
        .hilo_sel_o   (hilo_sel),
        .stall_o      (stall_o)
    );

    div_counter #(.WORD_W(WORD_W)) div_cnt_i (
        .clk     (clk),
        .reset_i (reset_i),
        .run_i   (div_run),
        .last_o  (div_last)
    );

    alu_core alu_i (
        .aluop_i  (aluop_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .hi_i     (hi),
        .lo_i     (lo),
        .wreg_i   (wreg_i),
        .result_o (alu_result),
        .wreg_o   (wreg_o)
    );

    mul_unit mul_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .mul_signed_i (mul_signed),
        .acc_load_i   (acc_load),
        .acc_sub_i    (acc_sub),
        .hi_i         (hi),
        .lo_i         (lo),
        .product_o    (product),
        .acc_sum_o    (acc_sum)
    );

    div_datapath #(.WORD_W(WORD_W)) div_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .run_i       (div_run),
        .signed_i    (div_signed),
        .dividend_i  (reg1_i),
        .divisor_i   (reg2_i),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    hilo_reg hilo_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .hi_we_i     (hi_we),
        .lo_we_i     (lo_we),
        .sel_i       (hilo_sel),
        .reg1_i      (reg1_i),
        .product_i   (product),
        .acc_sum_i   (acc_sum),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .hi_o        (hi),
        .lo_o        (lo)
    );

    assign wdata_o = (aluop_i == OP_MUL) ? product[WORD_W-1:0] : alu_result;   // MUL low word
    assign hi_o    = hi;
    assign lo_o    = lo;

endmodule

`default_nettype wire

// ==== source/hilo_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module hilo_reg (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          hi_we_i,
    input  logic                          lo_we_i,
    input  exec_pkg::hilo_src_e           sel_i,
    input  logic [exec_pkg::WORD_W-1:0]   reg1_i,
    input  logic [2*exec_pkg::WORD_W-1:0] product_i,
    input  logic [2*exec_pkg::WORD_W-1:0] acc_sum_i,
    input  logic [exec_pkg::WORD_W-1:0]   quotient_i,
    input  logic [exec_pkg::WORD_W-1:0]   remainder_i,
    output logic [exec_pkg::WORD_W-1:0]   hi_o,
    output logic [exec_pkg::WORD_W-1:0]   lo_o
);
    import exec_pkg::*;

    logic [WORD_W-1:0] hi_d;
    logic [WORD_W-1:0] lo_d;

    always_comb begin
        case (sel_i)
            HILO_PROD: {hi_d, lo_d} = product_i;
            HILO_ACC:  {hi_d, lo_d} = acc_sum_i;
            HILO_DIV:  {hi_d, lo_d} = {remainder_i, quotient_i};
            default:   {hi_d, lo_d} = {reg1_i, reg1_i};   // enables pick the half
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (hi_we_i) hi_o <= hi_d;
            if (lo_we_i) lo_o <= lo_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [exec_pkg::WORD_W-1:0]   reg1_i,
    input  logic [exec_pkg::WORD_W-1:0]   reg2_i,
    input  logic                          mul_signed_i,
    input  logic                          acc_load_i,
    input  logic                          acc_sub_i,
    input  logic [exec_pkg::WORD_W-1:0]   hi_i,
    input  logic [exec_pkg::WORD_W-1:0]   lo_i,
    output logic [2*exec_pkg::WORD_W-1:0] product_o,
    output logic [2*exec_pkg::WORD_W-1:0] acc_sum_o
);
    import exec_pkg::*;

    logic [WORD_W-1:0]   mag1;
    logic [WORD_W-1:0]   mag2;
    logic [2*WORD_W-1:0] prod_mag;
    logic [2*WORD_W-1:0] acc_q;      // term added to HI/LO in the second cycle
    logic                neg1;
    logic                neg2;

    assign neg1 = mul_signed_i && reg1_i[WORD_W-1];
    assign neg2 = mul_signed_i && reg2_i[WORD_W-1];
    assign mag1 = neg1 ? -reg1_i : reg1_i;
    assign mag2 = neg2 ? -reg2_i : reg2_i;

    assign prod_mag  = {{WORD_W{1'b0}}, mag1} * {{WORD_W{1'b0}}, mag2};
    assign product_o = (neg1 ^ neg2) ? -prod_mag : prod_mag;   // restore sign

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q <= '0;
        end else if (acc_load_i) begin
            acc_q <= acc_sub_i ? -product_o : product_o;   // MSUB subtracts
        end
    end

    assign acc_sum_o = {hi_i, lo_i} + acc_q;

endmodule

`default_nettype wire

// ==== tb.f ====
source/exec_pkg.sv
source/alu_core.sv
source/mul_unit.sv
source/div_datapath.sv
source/div_counter.sv
source/exec_ctrl.sv
source/hilo_reg.sv
source/exec_unit.sv
test/exec_unit_chk.sv
test/exec_unit_tb.sv

// ==== test/exec_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_chk (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        stall_i,
    input logic [exec_pkg::WORD_W-1:0] hi_i,
    input logic [exec_pkg::WORD_W-1:0] lo_i
);

    int fail_count = 0;   // failures seen so far

    // controller is idle once reset releases
    idle_after_reset: assert property (@(posedge clk) reset_i |=> !stall_i)
        else begin
            fail_count++;
            $error("stall_o high in the cycle after reset");
        end

    // longest stall is a 33-cycle divide
    stall_bounded: assert property (@(posedge clk) disable iff (reset_i)
                                    $rose(stall_i) |-> ##[1:33] !stall_i)
        else begin
            fail_count++;
            $error("stall_o held high for more than 33 cycles");
        end

    hilo_frozen: assert property (@(posedge clk) disable iff (reset_i)
                                  stall_i |=> ($stable(hi_i) && $stable(lo_i)))
        else begin
            fail_count++;
            $error("HI/LO changed while stall_o was high");
        end

endmodule

bind exec_unit exec_unit_chk chk_i (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_o),
    .hi_i    (hi_o),
    .lo_i    (lo_o)
);

`default_nettype wire

// ==== test/exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    localparam int  CLK_NS = 40;
    localparam time LIMIT  = 200 * 34 * CLK_NS;   // 200 instructions of at most 34 cycles

    logic              clk;
    logic              reset_i;
    alu_op_e           aluop;
    logic [WORD_W-1:0] reg1;
    logic [WORD_W-1:0] reg2;
    logic              wreg;
    logic [WORD_W-1:0] wdata;
    logic              wreg_out;
    logic [WORD_W-1:0] hi;
    logic [WORD_W-1:0] lo;
    logic              stall;
    logic [31:0]       lfsr = 32'd87912;
    int                errors = 0;
    int                checks = 0;

    exec_unit exec_unit_i (
        .clk     (clk),
        .reset_i (reset_i),
        .aluop_i (aluop),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .wreg_i  (wreg),
        .wdata_o (wdata),
        .wreg_o  (wreg_out),
        .hi_o    (hi),
        .lo_o    (lo),
        .stall_o (stall)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word();
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < WORD_W; i++) begin
            w = {w[WORD_W-2:0], next_bit()};
        end
        return w;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // drive one instruction and its write enable on the falling edge
    task automatic drive_op(input alu_op_e op, input logic [WORD_W-1:0] a,
                            input logic [WORD_W-1:0] b, input logic w);
        @(negedge clk);
        aluop = op;
        reg1  = a;
        reg2  = b;
        wreg  = w;
        #1;   // comb outputs settle
    endtask

    task automatic present(input alu_op_e op, input logic [WORD_W-1:0] a,
                           input logic [WORD_W-1:0] b);
        drive_op(op, a, b, 1'b1);
    endtask

    function automatic int lead_bits(input logic [WORD_W-1:0] v, input logic b);
        int n;
        n = 0;
        while ((n < WORD_W) && (v[WORD_W-1-n] == b)) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [WORD_W-1:0] ref_result(input alu_op_e op,
                                                     input logic [WORD_W-1:0] a,
                                                     input logic [WORD_W-1:0] b);
        int sa;
        int sb;
        int s;
        sa = a;
        sb = b;
        s  = a[SHAMT_W-1:0];
        case (op)
            OP_OR:           return a | b;
            OP_AND:          return a & b;
            OP_NOR:          return ~(a | b);
            OP_XOR:          return a ^ b;
            OP_SLL:          return b << s;
            OP_SRL:          return b >> s;
            OP_SRA:          return (b >> s) | (b[WORD_W-1] ? ~({WORD_W{1'b1}} >> s) : '0);
            OP_ADD, OP_ADDU: return a + b;
            OP_SUB, OP_SUBU: return a - b;
            OP_SLT:          return (sa < sb) ? 1 : 0;
            OP_SLTU:         return (a < b) ? 1 : 0;
            OP_CLZ:          return lead_bits(a, 1'b0);
            OP_CLO:          return lead_bits(a, 1'b1);
            default:         return '0;
        endcase
    endfunction

    // write enable survives unless a trapping add/sub leaves the int range
    function automatic logic ref_wreg(input alu_op_e op, input logic [WORD_W-1:0] a,
                                      input logic [WORD_W-1:0] b);
        longint sum;
        sum = (op == OP_SUB) ? longint'(int'(a)) - longint'(int'(b))
                             : longint'(int'(a)) + longint'(int'(b));
        if ((op != OP_ADD) && (op != OP_SUB)) begin
            return 1'b1;
        end
        return sum == longint'(int'(sum));
    endfunction

    function automatic logic [63:0] ref_product(input logic [WORD_W-1:0] a,
                                                input logic [WORD_W-1:0] b, input logic sgn);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        sa = int'(a);
        sb = int'(b);
        ua = a;
        ub = b;
        return sgn ? sa * sb : ua * ub;
    endfunction

    task automatic test_logic_shift();
        alu_op_e           ops[7] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        for (int n = 0; n < 8; n++) begin
            a = rand_word();
            b = rand_word();
            b[WORD_W-1] = n[0];   // half the SRA cases are negative
            foreach (ops[k]) begin
                present(ops[k], a, b);
                check_equal($sformatf("wdata_o (%s)", ops[k].name()),
                            ref_result(ops[k], a, b), wdata);
            end
        end
    endtask

    task automatic test_arith();
        alu_op_e           ops[8] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
                                      OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic              w;
        for (int n = 0; n < 10; n++) begin
            a = (n == 0) ? '0 : rand_word();
            b = rand_word();
            foreach (ops[k]) begin
                w = next_bit();
                drive_op(ops[k], a, b, w);
                check_equal($sformatf("wdata_o (%s)", ops[k].name()),
                            ref_result(ops[k], a, b), wdata);
                check_equal($sformatf("wreg_o (%s)", ops[k].name()),
                            ref_wreg(ops[k], a, b) & w, wreg_out);
            end
        end
        present(OP_ADD, 32'h7fff_ffff, 32'h1);
        check_equal("wreg_o (ADD overflow)", 0, wreg_out);
        present(OP_ADDU, 32'h7fff_ffff, 32'h1);
        check_equal("wreg_o (ADDU)", 1, wreg_out);
        drive_op(OP_ADDU, 32'h7fff_ffff, 32'h1, 1'b0);
        check_equal("wreg_o (ADDU with wreg_i low)", 0, wreg_out);
        present(OP_SUB, 32'h8000_0000, 32'h1);
        check_equal("wreg_o (SUB overflow)", 0, wreg_out);
        present(OP_CLO, 32'hffff_ffff, 32'h0);
        check_equal("wdata_o (CLO all ones)", WORD_W, wdata);
    endtask

    task automatic test_mul();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [63:0]       p;
        logic [63:0]       prev;
        for (int n = 0; n < 4; n++) begin
            a = rand_word();
            b = rand_word();
            present(OP_MULT, a, b);
            present(OP_NOP, '0, '0);
            check_equal("hi_o:lo_o (MULT)", ref_product(a, b, 1'b1), {hi, lo});
            present(OP_MULTU, a, b);
            present(OP_NOP, '0, '0);
            check_equal("hi_o:lo_o (MULTU)", ref_product(a, b, 1'b0), {hi, lo});
            prev = {hi, lo};
            p    = ref_product(a, b, 1'b1);
            present(OP_MUL, a, b);
            check_equal("wdata_o (MUL)", p[WORD_W-1:0], wdata);
            present(OP_NOP, '0, '0);
            check_equal("hi_o:lo_o after MUL", prev, {hi, lo});
        end
    endtask

    task automatic test_hilo_moves();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] old_lo;
        a      = rand_word();
        b      = rand_word();
        old_lo = lo;
        present(OP_MTHI, a, '0);
        present(OP_NOP, '0, '0);
        check_equal("hi_o (MTHI)", a, hi);
        check_equal("lo_o (MTHI)", old_lo, lo);
        present(OP_MTLO, b, '0);
        present(OP_NOP, '0, '0);
        check_equal("lo_o (MTLO)", b, lo);
        check_equal("hi_o (MTLO)", a, hi);
        present(OP_MFHI, '0, '0);
        check_equal("wdata_o (MFHI)", a, wdata);
        present(OP_MFLO, '0, '0);
        check_equal("wdata_o (MFLO)", b, wdata);
    endtask

    task automatic test_accumulate();
        alu_op_e           ops[4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] h;
        logic [WORD_W-1:0] l;
        logic [63:0]       p;
        logic [63:0]       acc;
        foreach (ops[k]) begin
            a = rand_word();
            b = rand_word();
            h = rand_word();
            l = rand_word();
            present(OP_MTHI, h, '0);
            present(OP_MTLO, l, '0);
            present(ops[k], a, b);
            check_equal($sformatf("stall_o first cycle (%s)", ops[k].name()), 1, stall);
            @(negedge clk);   // same instruction held
            #1;
            check_equal($sformatf("stall_o second cycle (%s)", ops[k].name()), 0, stall);
            present(OP_NOP, '0, '0);
            p   = ref_product(a, b, (ops[k] == OP_MADD) || (ops[k] == OP_MSUB));
            acc = ((ops[k] == OP_MSUB) || (ops[k] == OP_MSUBU)) ? {h, l} - p : {h, l} + p;
            check_equal($sformatf("hi_o:lo_o (%s)", ops[k].name()), acc, {hi, lo});
        end
    endtask

    task automatic run_divide(input alu_op_e op, input logic [WORD_W-1:0] a,
                              input logic [WORD_W-1:0] b);
        logic [WORD_W-1:0] q;
        logic [WORD_W-1:0] r;
        int                cycles;
        if (b == '0) begin
            q = '1;   // unsigned divide by zero
            r = a;
        end else if (op == OP_DIV) begin
            q = int'(a) / int'(b);   // truncates toward zero
            r = int'(a) % int'(b);   // sign of the dividend
        end else begin
            q = a / b;
            r = a % b;
        end
        present(op, a, b);
        cycles = 0;
        while (stall && (cycles < 40)) begin
            cycles++;
            @(negedge clk);
            #1;
        end
        present(OP_NOP, '0, '0);
        check_equal($sformatf("stall_o cycles (%s)", op.name()), 33, cycles);
        check_equal($sformatf("lo_o (%s)", op.name()), q, lo);
        check_equal($sformatf("hi_o (%s)", op.name()), r, hi);
    endtask

    task automatic test_divide();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] s;
        for (int n = 0; n < 8; n++) begin
            a = rand_word();
            s = rand_word();
            b = rand_word() >> s[4:0];   // spread of divisor sizes
            if (s[5]) begin
                b = -b;
            end
            if (b == '0) begin
                b = 32'd7;
            end
            run_divide(n[0] ? OP_DIVU : OP_DIV, a, b);
        end
        run_divide(OP_DIVU, rand_word(), '0);
    endtask

    initial begin
        clk     = 1'b0;
        reset_i = 1'b1;
        aluop   = OP_NOP;
        reg1    = '0;
        reg2    = '0;
        wreg    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        #1;
        check_equal("stall_o after reset", 0, stall);
        check_equal("hi_o:lo_o after reset", 0, {hi, lo});
        test_logic_shift();
        test_arith();
        test_mul();
        test_hilo_moves();
        test_accumulate();
        test_divide();
        @(negedge clk);
        errors += exec_unit_i.chk_i.fail_count;   // bound assertion failures
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired before the tests completed");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
